/* hdl/qspi_nor_pkg.sv */
// widths, command and nor cycle codes, phase states and request structs for the qspi nor bridge
package qspi_nor_pkg;

    // widths
    localparam int ADDR_BITS    = 26; // nor address
    localparam int DATA_BITS    = 16; // bus data
    localparam int IOREG_BITS   = 32; // one qspi transaction word
    localparam int NOR_CMD_BITS = 6;  // nor cycle code, top of wb address
    localparam int WB_ADDR_BITS = NOR_CMD_BITS + ADDR_BITS;

    // phase lengths in shifter cycles
    localparam int CMD_CYCLES   = 8;  // single spi
    localparam int ADDR_CYCLES  = 8;  // quad
    localparam int DATA_CYCLES  = 4;  // quad
    localparam int STALL_CYCLES = 20; // fast read dummy phase

    // request queue
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

    typedef logic [IOREG_BITS-1:0]    ioword_t;
    typedef logic [ADDR_BITS-1:0]     nor_addr_t;
    typedef logic [DATA_BITS-1:0]     bus_data_t;
    typedef logic [7:0]               spi_cmd_t;
    typedef logic [7:0]               txn_count_t;  // cycles minus one
    typedef logic [NOR_CMD_BITS-1:0]  nor_cmd_t;
    typedef logic [WB_ADDR_BITS-1:0]  wb_addr_t;
    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_BITS-1:0] fifo_cnt_t;

    // spi command bytes
    localparam spi_cmd_t CMD_READ       = 8'h03;
    localparam spi_cmd_t CMD_FAST_READ  = 8'h0B;
    localparam spi_cmd_t CMD_PROG_WORD  = 8'h02;
    localparam spi_cmd_t CMD_WRITE_THRU = 8'h22;
    localparam spi_cmd_t CMD_LOOPBACK   = 8'hA5;
    localparam spi_cmd_t CMD_SECT_ERASE = 8'hD8;
    localparam spi_cmd_t CMD_BULK_ERASE = 8'hC7;
    localparam spi_cmd_t CMD_RESET      = 8'h99;
    localparam spi_cmd_t CMD_DET_VT     = 8'h4B;

    // nor bus cycle codes
    localparam nor_cmd_t NOR_READ         = 6'd1;
    localparam nor_cmd_t NOR_WRITE        = 6'd2;
    localparam nor_cmd_t NOR_PROGRAM      = 6'd3;
    localparam nor_cmd_t NOR_ERASE_SECTOR = 6'd4;
    localparam nor_cmd_t NOR_ERASE_CHIP   = 6'd5;
    localparam nor_cmd_t NOR_RESET        = 6'd6;

    // qspi phase fsm
    typedef enum logic [2:0] {
        CMD,
        ADDR,
        STALL,
        READ_DATA,
        WRITE_DATA,
        LOOP_DATA
    } spi_state_e;

    // shifter setup for the coming phase
    typedef struct packed {
        logic       quad;  // 0 = single spi
        logic       drive; // bridge drives sio
        txn_count_t count;
    } txn_cfg_t;

    // one queued nor bus cycle
    typedef struct packed {
        nor_cmd_t  cycle;
        nor_addr_t addr;
        logic      we;
        bus_data_t data; // zero for reads and erases
    } nor_req_t;

endpackage

/* hdl/qspi_cmd_fsm.sv */
// qspi phase fsm with command and address latches, nor request generation and vt mode flag
`timescale 1ns/100ps

module qspi_cmd_fsm (
    input  logic                   txndone_i,  // one edge per completed word
    input  logic                   reset_i,
    input  logic                   txnreset_i, // chip enable high
    input  qspi_nor_pkg::ioword_t  txndata_i,
    input  qspi_nor_pkg::ioword_t  rd_data_i,  // last bus read
    output qspi_nor_pkg::txn_cfg_t txncfg_o,
    output qspi_nor_pkg::ioword_t  txndata_o,
    output logic                   vt_mode_o,
    output logic                   push_o,
    output qspi_nor_pkg::nor_req_t req_o
);

    qspi_nor_pkg::spi_state_e state_q;
    qspi_nor_pkg::spi_state_e state_d;
    qspi_nor_pkg::spi_cmd_t   cmd_q;
    qspi_nor_pkg::spi_cmd_t   cur_cmd;
    qspi_nor_pkg::nor_addr_t  addr_q;
    logic                     push_d;

    // spi command to nor bus cycle
    function automatic qspi_nor_pkg::nor_cmd_t nor_cycle(input qspi_nor_pkg::spi_cmd_t cmd);
        case (cmd)
            qspi_nor_pkg::CMD_READ,
            qspi_nor_pkg::CMD_FAST_READ:  nor_cycle = qspi_nor_pkg::NOR_READ;
            qspi_nor_pkg::CMD_PROG_WORD:  nor_cycle = qspi_nor_pkg::NOR_PROGRAM;
            qspi_nor_pkg::CMD_WRITE_THRU: nor_cycle = qspi_nor_pkg::NOR_WRITE;
            qspi_nor_pkg::CMD_SECT_ERASE: nor_cycle = qspi_nor_pkg::NOR_ERASE_SECTOR;
            qspi_nor_pkg::CMD_BULK_ERASE: nor_cycle = qspi_nor_pkg::NOR_ERASE_CHIP;
            qspi_nor_pkg::CMD_RESET:      nor_cycle = qspi_nor_pkg::NOR_RESET;
            default:                      nor_cycle = '0;
        endcase
    endfunction

    // command byte is still on txndata_i during the cmd phase
    assign cur_cmd = (state_q == qspi_nor_pkg::CMD) ? txndata_i[7:0] : cmd_q;

    // next phase and request for the word now completing
    always_comb begin
        state_d     = qspi_nor_pkg::CMD;
        push_d      = 1'b0;
        req_o       = '0;
        req_o.cycle = nor_cycle(cur_cmd);
        case (state_q)
            qspi_nor_pkg::CMD: begin
                case (cur_cmd)
                    qspi_nor_pkg::CMD_BULK_ERASE,
                    qspi_nor_pkg::CMD_RESET: push_d = 1'b1; // no address, addr stays zero
                    qspi_nor_pkg::CMD_READ,
                    qspi_nor_pkg::CMD_FAST_READ,
                    qspi_nor_pkg::CMD_PROG_WORD,
                    qspi_nor_pkg::CMD_WRITE_THRU,
                    qspi_nor_pkg::CMD_LOOPBACK,
                    qspi_nor_pkg::CMD_SECT_ERASE: state_d = qspi_nor_pkg::ADDR;
                    default: state_d = qspi_nor_pkg::CMD; // det_vt and unknown codes
                endcase
            end
            qspi_nor_pkg::ADDR: begin
                req_o.addr = txndata_i[qspi_nor_pkg::ADDR_BITS-1:0];
                case (cmd_q)
                    qspi_nor_pkg::CMD_READ: begin
                        push_d  = 1'b1;
                        state_d = qspi_nor_pkg::READ_DATA;
                    end
                    qspi_nor_pkg::CMD_FAST_READ: begin
                        push_d  = 1'b1; // bus read runs during the stall
                        state_d = qspi_nor_pkg::STALL;
                    end
                    qspi_nor_pkg::CMD_SECT_ERASE: push_d = 1'b1;
                    qspi_nor_pkg::CMD_PROG_WORD,
                    qspi_nor_pkg::CMD_WRITE_THRU: state_d = qspi_nor_pkg::WRITE_DATA;
                    qspi_nor_pkg::CMD_LOOPBACK:   state_d = qspi_nor_pkg::LOOP_DATA;
                    default:                      state_d = qspi_nor_pkg::CMD;
                endcase
            end
            qspi_nor_pkg::STALL: state_d = qspi_nor_pkg::READ_DATA;
            qspi_nor_pkg::WRITE_DATA: begin
                // write data goes straight into the request
                req_o.addr = addr_q;
                req_o.we   = 1'b1;
                req_o.data = txndata_i[qspi_nor_pkg::DATA_BITS-1:0];
                push_d     = 1'b1;
            end
            default: state_d = qspi_nor_pkg::CMD; // read and loopback data
        endcase
    end

    // an aborted word is not consumed
    assign push_o = push_d & ~txnreset_i;

    always_ff @(posedge txndone_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= qspi_nor_pkg::CMD;
        end else if (txnreset_i) begin
            state_q <= qspi_nor_pkg::CMD;
        end else begin
            state_q <= state_d;
        end
    end

    // command and address latches
    always_ff @(posedge txndone_i or posedge reset_i) begin
        if (reset_i) begin
            cmd_q  <= '0;
            addr_q <= '0;
        end else if (!txnreset_i) begin
            if (state_q == qspi_nor_pkg::CMD)
                cmd_q <= txndata_i[7:0];
            if (state_q == qspi_nor_pkg::ADDR)
                addr_q <= txndata_i[qspi_nor_pkg::ADDR_BITS-1:0];
        end
    end

    // vt mode follows the command that ended with chip enable
    always_ff @(posedge txndone_i or posedge reset_i) begin
        if (reset_i) begin
            vt_mode_o <= 1'b0;
        end else if (txnreset_i) begin
            if (cmd_q == qspi_nor_pkg::CMD_DET_VT)
                vt_mode_o <= 1'b1;
            else if (cmd_q == qspi_nor_pkg::CMD_RESET)
                vt_mode_o <= 1'b0;
        end
    end

    // shifter setup per phase
    always_comb begin
        txncfg_o.quad  = 1'b1;
        txncfg_o.drive = 1'b0;
        txncfg_o.count = qspi_nor_pkg::txn_count_t'(qspi_nor_pkg::DATA_CYCLES - 1);
        case (state_q)
            qspi_nor_pkg::CMD: begin
                txncfg_o.quad  = 1'b0; // command byte is single spi
                txncfg_o.count = qspi_nor_pkg::txn_count_t'(qspi_nor_pkg::CMD_CYCLES - 1);
            end
            qspi_nor_pkg::ADDR:
                txncfg_o.count = qspi_nor_pkg::txn_count_t'(qspi_nor_pkg::ADDR_CYCLES - 1);
            qspi_nor_pkg::STALL:
                txncfg_o.count = qspi_nor_pkg::txn_count_t'(qspi_nor_pkg::STALL_CYCLES - 1);
            qspi_nor_pkg::READ_DATA,
            qspi_nor_pkg::LOOP_DATA: txncfg_o.drive = 1'b1;
            default: txncfg_o.drive = 1'b0; // write data shifts in
        endcase
    end

    // loopback echoes the address back
    assign txndata_o = (cmd_q == qspi_nor_pkg::CMD_LOOPBACK) ?
                       qspi_nor_pkg::ioword_t'(addr_q) : rd_data_i;

endmodule

/* hdl/nor_req_fifo.sv */
// four entry nor request queue with sticky overflow flag
`timescale 1ns/100ps

module nor_req_fifo (
    input  logic                   txndone_i,
    input  logic                   reset_i,
    input  logic                   push_i,
    input  qspi_nor_pkg::nor_req_t req_i,
    input  logic                   pop_i,
    output qspi_nor_pkg::nor_req_t head_o,
    output logic                   nonempty_o,
    output logic                   overflow_o // set on a dropped push, held until reset
);

    qspi_nor_pkg::nor_req_t  mem_q [qspi_nor_pkg::FIFO_DEPTH];
    qspi_nor_pkg::fifo_ptr_t wr_ptr_q;
    qspi_nor_pkg::fifo_ptr_t rd_ptr_q;
    qspi_nor_pkg::fifo_cnt_t count_q;
    logic                    full;
    logic                    push_ok;
    logic                    pop_ok;

    assign full       = (count_q == qspi_nor_pkg::fifo_cnt_t'(qspi_nor_pkg::FIFO_DEPTH));
    assign nonempty_o = (count_q != '0);
    assign push_ok    = push_i & ~full;
    assign pop_ok     = pop_i & nonempty_o;
    assign head_o     = mem_q[rd_ptr_q];

    always_ff @(posedge txndone_i) begin
        if (push_ok)
            mem_q[wr_ptr_q] <= req_i;
    end

    always_ff @(posedge txndone_i or posedge reset_i) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two, wraps
            if (pop_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (push_i && full)
                overflow_o <= 1'b1; // host cannot be stalled, request lost
        end
    end

endmodule

/* hdl/wb_nor_master.sv */
// single cycle wishbone master that drains the request queue and holds the last read word
`timescale 1ns/100ps

module wb_nor_master (
    input  logic                    txndone_i,
    input  logic                    reset_i,
    input  logic                    nonempty_i,
    input  qspi_nor_pkg::nor_req_t  head_i,
    input  logic                    wb_ack_i,
    input  qspi_nor_pkg::bus_data_t wb_dat_i,
    output logic                    pop_o,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output qspi_nor_pkg::wb_addr_t  wb_adr_o,
    output qspi_nor_pkg::bus_data_t wb_dat_o,
    output qspi_nor_pkg::ioword_t   rd_data_o
);

    // take the head whenever no cycle is open
    assign pop_o = nonempty_i & ~wb_cyc_o;

    always_ff @(posedge txndone_i or posedge reset_i) begin
        if (reset_i) begin
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            wb_we_o   <= 1'b0;
            wb_adr_o  <= '0;
            wb_dat_o  <= '0;
            rd_data_o <= '0;
        end else if (!wb_cyc_o) begin
            if (nonempty_i) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
                wb_we_o  <= head_i.we;
                wb_adr_o <= {head_i.cycle, head_i.addr}; // cycle code rides above the address
                wb_dat_o <= head_i.data;
            end
        end else if (wb_ack_i) begin
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            // upper bits of the io word read as zero
            rd_data_o <= qspi_nor_pkg::ioword_t'(wb_dat_i);
        end
    end

endmodule

/* hdl/qspi_nor_bridge.sv */
// top level of the qspi to nor bridge: command fsm, request queue and wishbone master
`timescale 1ns/100ps

module qspi_nor_bridge (
    input  logic                    txndone_i,  // word clock from the qspi shifter
    input  logic                    reset_i,

    // qspi transaction side
    input  logic                    txnreset_i,
    input  qspi_nor_pkg::ioword_t   txndata_i,
    output qspi_nor_pkg::txn_cfg_t  txncfg_o,
    output qspi_nor_pkg::ioword_t   txndata_o,

    // nor bus
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output qspi_nor_pkg::wb_addr_t  wb_adr_o,
    output qspi_nor_pkg::bus_data_t wb_dat_o,
    input  logic                    wb_ack_i,
    input  qspi_nor_pkg::bus_data_t wb_dat_i,

    // status
    output logic                    vt_mode_o,
    output logic                    overflow_o
);

    logic                   push;
    logic                   pop;
    logic                   nonempty;
    qspi_nor_pkg::nor_req_t req;
    qspi_nor_pkg::nor_req_t head;
    qspi_nor_pkg::ioword_t  rd_data;

    qspi_cmd_fsm i_cmd_fsm (
        .txndone_i  (txndone_i),
        .reset_i    (reset_i),
        .txnreset_i (txnreset_i),
        .txndata_i  (txndata_i),
        .rd_data_i  (rd_data),
        .txncfg_o   (txncfg_o),
        .txndata_o  (txndata_o),
        .vt_mode_o  (vt_mode_o),
        .push_o     (push),
        .req_o      (req)
    );

    nor_req_fifo i_req_fifo (
        .txndone_i  (txndone_i),
        .reset_i    (reset_i),
        .push_i     (push),
        .req_i      (req),
        .pop_i      (pop),
        .head_o     (head),
        .nonempty_o (nonempty),
        .overflow_o (overflow_o)
    );

    wb_nor_master i_wb_master (
        .txndone_i  (txndone_i),
        .reset_i    (reset_i),
        .nonempty_i (nonempty),
        .head_i     (head),
        .wb_ack_i   (wb_ack_i),
        .wb_dat_i   (wb_dat_i),
        .pop_o      (pop),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .rd_data_o  (rd_data)
    );

endmodule

/* tests/tb_qspi_nor_bridge.sv */
// qspi nor bridge testbench with clock, trace reader, wishbone responder, checks and summary
`timescale 1ns/100ps

module tb_qspi_nor_bridge;

    // one expected bus cycle and the response to give it
    typedef struct packed {
        qspi_nor_pkg::nor_cmd_t  cycle;
        qspi_nor_pkg::nor_addr_t addr;
        logic                    we;
        qspi_nor_pkg::bus_data_t data;
        qspi_nor_pkg::bus_data_t rdata;
        logic [7:0]              stall; // 0 = random ack delay
    } bus_exp_t;

    logic                    txndone_i;
    logic                    reset_i;
    logic                    txnreset_i;
    qspi_nor_pkg::ioword_t   txndata_i;
    qspi_nor_pkg::txn_cfg_t  txncfg_o;
    qspi_nor_pkg::ioword_t   txndata_o;
    logic                    wb_cyc_o;
    logic                    wb_stb_o;
    logic                    wb_we_o;
    qspi_nor_pkg::wb_addr_t  wb_adr_o;
    qspi_nor_pkg::bus_data_t wb_dat_o;
    logic                    wb_ack_i;
    qspi_nor_pkg::bus_data_t wb_dat_i;
    logic                    vt_mode_o;
    logic                    overflow_o;

    bus_exp_t       bus_q[$];
    logic           busy;
    logic [31:0]    lfsr_q;
    integer         errors;
    integer         checks;
    integer         cycles;
    integer         limit;
    reg [8*32-1:0]  cur_name;
    integer         test_err_start;
    integer         tests_run;
    integer         tests_failed;

    qspi_nor_bridge i_dut (
        .txndone_i  (txndone_i),
        .reset_i    (reset_i),
        .txnreset_i (txnreset_i),
        .txndata_i  (txndata_i),
        .txncfg_o   (txncfg_o),
        .txndata_o  (txndata_o),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_i   (wb_ack_i),
        .wb_dat_i   (wb_dat_i),
        .vt_mode_o  (vt_mode_o),
        .overflow_o (overflow_o)
    );

    initial begin
        txndone_i = 1'b0;
        forever #50 txndone_i = ~txndone_i; // 100 ns word period
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_edge();
        @(posedge txndone_i);
        #10;
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic close_test();
        if (cur_name != 0) begin
            tests_run = tests_run + 1;
            if (errors != test_err_start)
                tests_failed = tests_failed + 1;
            $display("test %0s: %0s (%0d errors)", cur_name,
                     (errors == test_err_start) ? "ok" : "failed", errors - test_err_start);
        end
    endtask

    // wishbone slave model answering in trace order
    initial begin
        bus_exp_t    e;
        integer      delay;
        forever begin
            next_edge();
            if (wb_cyc_o && !reset_i) begin
                busy = 1'b1;
                delay = 0;
                e = '0;
                if (bus_q.size() == 0) begin
                    $display("bus cycle at %0d ns to %0h with no request expected",
                             $time, wb_adr_o);
                    errors = errors + 1;
                end else begin
                    e = bus_q.pop_front();
                    check("wb_stb_o", wb_stb_o, 1'b1);
                    check("wb_adr_o", wb_adr_o, {e.cycle, e.addr});
                    check("wb_we_o", wb_we_o, e.we);
                    check("wb_dat_o", wb_dat_o, e.data);
                    if (e.stall != 0) begin
                        delay = e.stall;
                    end else begin
                        lfsr_q = lfsr_next(lfsr_q);
                        delay = lfsr_q[0];
                        lfsr_q = lfsr_next(lfsr_q);
                        delay = delay * 2 + lfsr_q[0];
                    end
                end
                repeat (delay) next_edge();
                wb_ack_i = 1'b1;
                wb_dat_i = e.rdata;
                next_edge(); // master sees ack here
                wb_ack_i = 1'b0;
                wb_dat_i = '0;
                busy = 1'b0;
            end
        end
    end

    always @(posedge txndone_i) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        integer        fd;
        integer        rc;
        reg [8*32-1:0] tok;
        reg [8*256-1:0] line;
        logic [31:0]   f0, f1, f2, f3, f4, f5;
        bus_exp_t      e;
        reset_i = 1'b1;
        txnreset_i = 1'b0;
        txndata_i = '0;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        busy = 1'b0;
        lfsr_q = 32'h4cd1_c993;
        errors = 0;
        checks = 0;
        cycles = 0;
        limit = 0;
        cur_name = 0;
        test_err_start = 0;
        tests_run = 0;
        tests_failed = 0;
        fd = $fopen("tests/qspi_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/qspi_trace.txt");
            $display("RESULT: FAIL");
            $finish;
        end
        // first pass sizes the timeout
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok != "#")
                limit = limit + 40;
            rc = $fgets(line, fd);
        end
        $fclose(fd);
        limit = limit + 20; // reset time
        fd = $fopen("tests/qspi_trace.txt", "r");
        repeat (8) @(posedge txndone_i);
        #10;
        reset_i = 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(line, fd);
            end else if (tok == "S") begin
                rc = $fscanf(fd, "%s", tok);
                check("S record fields", rc, 1);
                close_test();
                cur_name = tok;
                test_err_start = errors;
            end else if (tok == "T") begin
                rc = $fscanf(fd, "%h %h %h %h %d", f0, f1, f2, f3, f4);
                check("T record fields", rc, 5);
                check("txncfg_o", txncfg_o, {f2[0], f3[0], f4[7:0]});
                txnreset_i = f0[0];
                txndata_i = f1;
                next_edge();
            end else if (tok == "B") begin
                rc = $fscanf(fd, "%h %h %h %h %h %d", f0, f1, f2, f3, f4, f5);
                check("B record fields", rc, 6);
                e.cycle = f0[5:0];
                e.addr = f1[25:0];
                e.we = f2[0];
                e.data = f3[15:0];
                e.rdata = f4[15:0];
                e.stall = f5[7:0];
                bus_q.push_back(e);
            end else if (tok == "D") begin
                rc = $fscanf(fd, "%h", f0);
                check("D record fields", rc, 1);
                check("txndata_o", txndata_o, f0);
            end else if (tok == "V") begin
                rc = $fscanf(fd, "%h %h", f0, f1);
                check("V record fields", rc, 2);
                check("vt_mode_o", vt_mode_o, f0[0]);
                check("overflow_o", overflow_o, f1[0]);
            end else if (tok == "W") begin
                // idle words until the bus has drained
                while (bus_q.size() != 0 || busy || wb_cyc_o) begin
                    txnreset_i = 1'b0;
                    txndata_i = '0;
                    next_edge();
                end
            end else begin
                $display("trace record %0s is not recognized", tok);
                errors = errors + 1;
                rc = $fgets(line, fd);
            end
        end
        $fclose(fd);
        close_test();
        if (bus_q.size() != 0) begin
            $display("%0d expected bus cycles never appeared", bus_q.size());
            errors = errors + 1;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tests/qspi_trace.txt */
# S name | T txnreset txndata quad drive count | B cycle addr we data rdata stall
# D txndata_o | V vt_mode overflow | W wait for bus idle
S reset_state
V 0 0
D 00000000
T 0 00000000 0 0 7
S phase_cfg
B 01 0123400 0 0000 beef 0
T 0 0000000b 0 0 7
T 0 00123400 1 0 7
T 0 00000000 1 0 19
T 0 00000000 1 1 3
W
D 0000beef
B 02 0000abc 1 5a5a 0000 0
T 0 00000022 0 0 7
T 0 00000abc 1 0 7
T 0 00005a5a 1 0 3
T 0 00000000 0 0 7
W
S bus_requests
B 03 0000100 1 c0de 0000 0
T 0 00000002 0 0 7
T 0 00000100 1 0 7
T 0 0000c0de 1 0 3
B 04 0200000 0 0000 0000 0
T 0 000000d8 0 0 7
T 0 00200000 1 0 7
B 05 0000000 0 0000 0000 0
T 0 000000c7 0 0 7
B 06 0000000 0 0000 0000 0
T 0 00000099 0 0 7
W
S read_return
B 01 3ffffff 0 0000 1234 0
T 0 00000003 0 0 7
T 0 03ffffff 1 0 7
T 0 00000000 1 1 3
W
D 00001234
T 0 000000a5 0 0 7
T 0 00155aa5 1 0 7
T 0 00000000 1 1 3
D 00155aa5
S abort
T 0 00000003 0 0 7
T 1 00000000 1 0 7
T 0 00000000 0 0 7
W
T 0 0000004b 0 0 7
T 1 00000000 0 0 7
V 1 0
B 06 0000000 0 0000 0000 0
T 0 00000099 0 0 7
T 1 00000000 0 0 7
V 0 0
W
S overflow
B 05 0000000 0 0000 0000 10
B 05 0000000 0 0000 0000 0
B 05 0000000 0 0000 0000 0
B 05 0000000 0 0000 0000 0
B 05 0000000 0 0000 0000 0
T 0 000000c7 0 0 7
T 0 000000c7 0 0 7
T 0 000000c7 0 0 7
T 0 000000c7 0 0 7
T 0 000000c7 0 0 7
T 0 000000c7 0 0 7
V 0 1
W
T 0 00000000 0 0 7
T 0 00000000 0 0 7
W
V 0 1

/* project.f */
hdl/qspi_nor_pkg.sv
hdl/qspi_cmd_fsm.sv
hdl/nor_req_fifo.sv
hdl/wb_nor_master.sv
hdl/qspi_nor_bridge.sv
tests/tb_qspi_nor_bridge.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_qspi_nor_bridge \
    -f project.f -o Vtb_qspi_nor_bridge || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_qspi_nor_bridge)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
